/* list.f */
src/l2_pkg.sv
src/sram_512x128.sv
src/l2_data_ram.sv
src/l2_tag_ram.sv
src/l2_cache_ctrl.sv
src/l2_cache.sv
tests/tb_l2_cache.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_l2_cache -o sim_l2_cache
output=$(./obj_dir/sim_l2_cache)
echo "$output"
if grep -qx "Finished with no errors" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* src/l2_cache.sv */
// l2 cache top: controller, tag array and data array
`timescale 1ns/10ps
`default_nettype none

module l2_cache
    import l2_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              req_valid,
    input  wire l2_req_t     req,
    output logic             resp_valid,
    output l2_resp_t         resp,
    output logic             busy,
    output logic             mem_rd_req,
    output line_addr_t       mem_rd_addr,
    input  wire              mem_rd_valid,
    input  wire line_t       mem_rd_line,
    output logic             mem_wr_valid,
    output mem_wr_t          mem_wr
);

    index_t    index;
    offset_t   offset;
    tag_t      lookup_tag;
    logic      tag_fill;
    way_t      fill_way;
    way_mask_t way_we;
    logic      word_write;
    word_t     wdata;
    line_t     fill_line;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    line_t     way_lines [NUM_WAYS];

    l2_cache_ctrl i_l2_cache_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .way_lines    (way_lines),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_line  (mem_rd_line),
        .index        (index),
        .offset       (offset),
        .lookup_tag   (lookup_tag),
        .tag_fill     (tag_fill),
        .fill_way     (fill_way),
        .way_we       (way_we),
        .word_write   (word_write),
        .wdata        (wdata),
        .fill_line    (fill_line),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr),
        .busy         (busy)
    );

    l2_tag_ram i_l2_tag_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (index),
        .tag        (lookup_tag),
        .fill       (tag_fill),
        .fill_way   (fill_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    l2_data_ram i_l2_data_ram (
        .clk        (clk),
        .index      (index),
        .offset     (offset),
        .way_we     (way_we),
        .word_write (word_write),
        .wdata      (wdata),
        .fill_line  (fill_line),
        .way_lines  (way_lines)
    );

endmodule

`default_nettype wire

/* src/l2_cache_ctrl.sv */
// l2 cache controller: lookup, read-miss refill, write-through and response FSM
`timescale 1ns/10ps
`default_nettype none

module l2_cache_ctrl
    import l2_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             req_valid,
    input  wire l2_req_t    req,
    input  wire             hit,
    input  wire way_t       hit_way,
    input  wire way_t       victim_way,
    input  wire line_t      way_lines [NUM_WAYS],
    input  wire             mem_rd_valid,
    input  wire line_t      mem_rd_line,
    output index_t          index,
    output offset_t         offset,
    output tag_t            lookup_tag,
    output logic            tag_fill,
    output way_t            fill_way,
    output way_mask_t       way_we,
    output logic            word_write,
    output word_t           wdata,
    output line_t           fill_line,
    output logic            resp_valid,
    output l2_resp_t        resp,
    output logic            mem_rd_req,
    output line_addr_t      mem_rd_addr,
    output logic            mem_wr_valid,
    output mem_wr_t         mem_wr,
    output logic            busy
);

    ctrl_state_t state;
    logic        mem_rd_req_q;
    l2_req_t     req_q;
    way_t        victim_q;
    line_t       line_q;
    l2_resp_t    resp_q;
    word_addr_t  cur_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            mem_rd_req_q <= 1'b0;
        end else begin
            mem_rd_req_q <= 1'b0;   // single-cycle strobe
            case (state)
                ST_IDLE:    if (req_valid) state <= ST_LOOKUP;
                ST_LOOKUP: begin
                    if (!req_q.write && !hit) begin
                        mem_rd_req_q <= 1'b1;
                        state        <= ST_REFILL;
                    end else begin
                        state <= ST_RESPOND;
                    end
                end
                ST_REFILL:  if (mem_rd_valid) state <= ST_RESPOND;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // request, victim and response payload
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (req_valid) req_q <= req;
            end
            ST_LOOKUP: begin
                victim_q    <= victim_way;
                resp_q.hit  <= hit;
                resp_q.rdata <= req_q.write ? '0 : line_word(way_lines[hit_way], addr_offset(req_q.addr));
            end
            ST_REFILL: begin
                if (mem_rd_valid) begin
                    line_q       <= mem_rd_line;
                    resp_q.hit   <= 1'b0;
                    resp_q.rdata <= line_word(mem_rd_line, addr_offset(req_q.addr));
                end
            end
            default: ;
        endcase
    end

    // arrays see the incoming request while idle, the latched one afterwards
    assign cur_addr   = (state == ST_IDLE) ? req.addr : req_q.addr;
    assign index      = addr_index(cur_addr);
    assign offset     = addr_offset(cur_addr);
    assign lookup_tag = addr_tag(cur_addr);

    // refill lands in the response cycle of a read miss
    assign tag_fill   = (state == ST_RESPOND) && !req_q.write && !resp_q.hit;
    assign fill_way   = victim_q;
    assign fill_line  = line_q;
    assign word_write = (state == ST_LOOKUP);
    assign wdata      = req_q.wdata;

    always_comb begin
        way_we = '0;
        if (state == ST_LOOKUP && req_q.write && hit) begin
            way_we = way_mask_t'(1) << hit_way;     // write hit, one slice
        end else if (tag_fill) begin
            way_we = way_mask_t'(1) << victim_q;    // whole line
        end
    end

    assign resp_valid   = (state == ST_RESPOND);
    assign resp         = resp_q;
    assign mem_rd_req   = mem_rd_req_q;
    assign mem_rd_addr  = addr_line(req_q.addr);
    assign mem_wr_valid = (state == ST_LOOKUP) && req_q.write;  // write-through, hit or miss
    assign mem_wr       = '{addr: req_q.addr, wdata: req_q.wdata};
    assign busy         = (state != ST_IDLE);

    a_no_req_while_busy : assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !busy)
        else $error("l2_cache_ctrl: req_valid while busy");

endmodule

`default_nettype wire

/* src/l2_data_ram.sv */
// l2 data array: four ways of 512-bit lines split over 128-bit SRAM slices
`timescale 1ns/10ps
`default_nettype none

module l2_data_ram
    import l2_pkg::*;
(
    input  wire            clk,
    input  wire index_t    index,
    input  wire offset_t   offset,
    input  wire way_mask_t way_we,
    input  wire            word_write,   // one slice from wdata, else whole line
    input  wire word_t     wdata,
    input  wire line_t     fill_line,
    output line_t          way_lines [NUM_WAYS]
);

    line_t wr_line;

    // refill line by default, write word dropped into its slot
    always_comb begin
        wr_line = fill_line;
        if (word_write) begin
            wr_line[offset*WORD_BITS +: WORD_BITS] = wdata;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar s = 0; s < WORDS_PER_LINE; s++) begin : g_slice
            logic slice_we;

            // word write touches only the addressed slice
            assign slice_we = way_we[w] && (!word_write || offset == offset_t'(s));

            sram_512x128 i_sram (
                .clk     (clk),
                .address (index),
                .wren    (slice_we),
                .data    (wr_line[s*WORD_BITS +: WORD_BITS]),
                .q       (way_lines[w][s*WORD_BITS +: WORD_BITS])
            );
        end
    end

    // controller never writes two ways in one cycle
    a_way_we_onehot : assert property (@(posedge clk) $onehot0(way_we))
        else $error("l2_data_ram: way_we %b selects more than one way", way_we);

endmodule

`default_nettype wire

/* src/l2_pkg.sv */
// l2 cache shared types: widths, address split, request, response and memory structs
`default_nettype none

package l2_pkg;

    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 512;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS      = 128;

    typedef logic [WORD_BITS-1:0]                word_t;
    typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;      // word 0 in the low bits
    typedef logic [8:0]                          index_t;
    typedef logic [15:0]                         tag_t;
    typedef logic [1:0]                          offset_t;
    typedef logic [1:0]                          way_t;
    typedef logic [NUM_WAYS-1:0]                 way_mask_t;  // one-hot
    typedef logic [26:0]                         word_addr_t; // {tag, index, offset}
    typedef logic [24:0]                         line_addr_t; // {tag, index}

    function automatic tag_t addr_tag(word_addr_t a);
        return a[26:11];
    endfunction

    function automatic index_t addr_index(word_addr_t a);
        return a[10:2];
    endfunction

    function automatic offset_t addr_offset(word_addr_t a);
        return a[1:0];
    endfunction

    function automatic line_addr_t addr_line(word_addr_t a);
        return a[26:2];
    endfunction

    // pick one word out of a line
    function automatic word_t line_word(line_t l, offset_t o);
        return l[o*WORD_BITS +: WORD_BITS];
    endfunction

    typedef struct packed {
        logic       write;
        word_addr_t addr;
        word_t      wdata;
    } l2_req_t;

    typedef struct packed {
        logic  hit;
        word_t rdata;   // zero for writes
    } l2_resp_t;

    typedef struct packed {
        word_addr_t addr;
        word_t      wdata;
    } mem_wr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL,
        ST_RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

/* src/l2_tag_ram.sv */
// l2 tag array: per-way tags and valid bits, hit compare and round-robin victim per set
`timescale 1ns/10ps
`default_nettype none

module l2_tag_ram
    import l2_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire index_t index,
    input  wire tag_t   tag,
    input  wire         fill,
    input  wire way_t   fill_way,
    output logic        hit,
    output way_t        hit_way,
    output way_t        victim_way
);

    tag_t                tags       [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] valid      [NUM_SETS];
    way_t                victim_ptr [NUM_SETS];
    index_t              index_q;
    tag_t                tag_q;
    logic                dup_tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]      <= '0;
                victim_ptr[s] <= '0;
            end
        end else if (fill) begin
            valid[index][fill_way] <= 1'b1;
            victim_ptr[index]      <= victim_ptr[index] + 2'd1;  // wraps at 4
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_way][index] <= tag;
        end
        index_q <= index;   // compare one cycle later, with the data array
        tag_q   <= tag;
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid[index_q][w] && tags[w][index_q] == tag_q) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign victim_way = victim_ptr[index_q];

    // a miss followed by refill must never create a second copy of a tag
    always_comb begin
        dup_tag = 1'b0;
        for (int a = 0; a < NUM_WAYS; a++) begin
            for (int b = a + 1; b < NUM_WAYS; b++) begin
                if (valid[index_q][a] && valid[index_q][b] &&
                    tags[a][index_q] == tags[b][index_q]) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    a_no_dup_tag : assert property (@(posedge clk) disable iff (!rst_n) !dup_tag)
        else $error("l2_tag_ram: set %0d holds the same tag in two valid ways", index_q);

endmodule

`default_nettype wire

/* src/sram_512x128.sv */
// single-port synchronous RAM of 512 words by 128 bits with registered read data
`timescale 1ns/10ps
`default_nettype none

module sram_512x128
    import l2_pkg::*;
(
    input  wire         clk,
    input  wire index_t address,
    input  wire         wren,
    input  wire word_t  data,
    output word_t       q
);

    word_t mem [NUM_SETS];

    // read returns the old word during a write
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
        q <= mem[address];
    end

endmodule

`default_nettype wire

/* tests/l2_stimulus.txt */
# test  op  word_addr(hex)  wdata(hex)  expected_rdata(hex)  expected_hit
# unwritten memory words read as the 27-bit address zero-extended to 32 bits, four times
1 read 0000814 0 00000814000008140000081400000814 0
2 read 0000817 0 00000817000008170000081700000817 1
3 read 0000815 0 00000815000008150000081500000815 1
4 write 0000816 a5a5a5a50f0f0f0f12345678deadbeef 0 1
5 read 0000816 0 a5a5a5a50f0f0f0f12345678deadbeef 1
6 read 0000815 0 00000815000008150000081500000815 1
7 read 0000814 0 00000814000008140000081400000814 1
8 write 000101d 0123456789abcdeffedcba9876543210 0 0
9 read 000101d 0 0123456789abcdeffedcba9876543210 0
10 read 000101c 0 0000101c0000101c0000101c0000101c 1
11 read 0001824 0 00001824000018240000182400001824 0
12 read 0002024 0 00002024000020240000202400002024 0
13 read 0002824 0 00002824000028240000282400002824 0
14 read 0003024 0 00003024000030240000302400003024 0
15 read 0003824 0 00003824000038240000382400003824 0
16 read 0002025 0 00002025000020250000202500002025 1
17 read 0001826 0 00001826000018260000182600001826 0
18 read 0003825 0 00003825000038250000382500003825 1
19 read 0055fff 0 00055fff00055fff00055fff00055fff 0
20 read 0055ffc 0 00055ffc00055ffc00055ffc00055ffc 1
21 read 7fff802 0 07fff80207fff80207fff80207fff802 0
22 read 7fff801 0 07fff80107fff80107fff80107fff801 1
23 write 7fff803 5555aaaa5555aaaa3333cccc3333cccc 0 1
24 read 7fff803 0 5555aaaa5555aaaa3333cccc3333cccc 1
25 read 091a2a8 0 0091a2a80091a2a80091a2a80091a2a8 0
26 read 091a2ad 0 0091a2ad0091a2ad0091a2ad0091a2ad 0
27 read 091a2aa 0 0091a2aa0091a2aa0091a2aa0091a2aa 1
28 write 091a2b0 cafef00dcafef00d0badc0de0badc0de 0 0
29 read 091a2b0 0 cafef00dcafef00d0badc0de0badc0de 0

/* tests/tb_l2_cache.sv */
// l2 cache testbench: replays a stimulus file against the cache with a latency-varying memory
`timescale 1ns/10ps
`default_nettype none

module tb_l2_cache
    import l2_pkg::*;
();

    typedef struct packed {
        logic [31:0] num;
        logic        write;
        word_addr_t  addr;
        word_t       wdata;
        word_t       exp_rdata;
        logic        exp_hit;
    } stim_t;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    l2_req_t    req;
    logic       resp_valid;
    l2_resp_t   resp;
    logic       busy;
    logic       mem_rd_req;
    line_addr_t mem_rd_addr;
    logic       mem_rd_valid;
    line_t      mem_rd_line;
    logic       mem_wr_valid;
    mem_wr_t    mem_wr;

    stim_t       tests [$];
    word_t       mem_words [word_addr_t];     // words written through to memory
    logic [31:0] lfsr_state = 32'hc2401aa6;
    int          errors = 0;
    int          passed = 0;
    int          watchdog_cycles = 0;

    l2_cache i_l2_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .busy         (busy),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_line  (mem_rd_line),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic lfsr_next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h80200003;
        return b;
    endfunction

    // unwritten words read back as their own address, four times over
    function automatic word_t mem_read(word_addr_t a);
        if (mem_words.exists(a)) return mem_words[a];
        return {4{5'b0, a}};
    endfunction

    task automatic report_mismatch(string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] num;
        logic [39:0] op;
        word_addr_t  addr;
        word_t       wdata;
        word_t       exp_rdata;
        logic [31:0] exp_hit;
        fd = $fopen("tests/l2_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("could not open tests/l2_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt == 0 || line.len() < 2 || line.getc(0) == "#") continue;  // blank or comment
            cnt = $sscanf(line, "%d %s %h %h %h %d", num, op, addr, wdata, exp_rdata, exp_hit);
            if (cnt != 6 || (op != "read" && op != "write")) begin
                report_failure($sformatf("unreadable stimulus line: %s", line));
                continue;
            end
            tests.push_back('{num: num, write: (op == "write"), addr: addr, wdata: wdata,
                              exp_rdata: exp_rdata, exp_hit: exp_hit[0]});
        end
        $fclose(fd);
    endtask

    task automatic run_test(input stim_t t);
        int       n;
        int       wr_seen;
        int       rd_seen;
        int       errs_before;
        logic     got;
        l2_resp_t r;
        mem_wr_t  w;
        errs_before = errors;
        n = 1;
        wr_seen = 0;
        rd_seen = 0;
        got = 1'b0;
        r = '0;
        w = '0;
        while (busy) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{write: t.write, addr: t.addr, wdata: t.wdata};
        @(posedge clk);
        req_valid <= 1'b0;
        while (!got && n <= 32) begin     // n is the cycle count since req_valid
            @(negedge clk);
            if (mem_wr_valid) begin
                wr_seen++;
                w = mem_wr;
            end
            if (mem_rd_req) rd_seen++;
            if (resp_valid) begin
                got = 1'b1;
                r = resp;
            end else begin
                if (!busy) report_failure($sformatf("test %0d: busy low before response", t.num));
                n++;
            end
        end
        if (!got) begin
            report_failure($sformatf("test %0d: no response within 32 cycles", t.num));
        end else begin
            if (r.hit !== t.exp_hit)
                report_mismatch($sformatf("test %0d hit %b, expected %b", t.num, r.hit, t.exp_hit));
            if (r.rdata !== t.exp_rdata)
                report_mismatch($sformatf("test %0d rdata %h, expected %h",
                                          t.num, r.rdata, t.exp_rdata));
            if ((t.write || t.exp_hit) && n != 2)
                report_mismatch($sformatf("test %0d response after %0d cycles, expected 2",
                                          t.num, n));
        end
        if (t.write && wr_seen != 1) begin
            report_failure($sformatf("test %0d: expected one memory write, saw %0d",
                                     t.num, wr_seen));
        end else if (t.write && (w.addr !== t.addr || w.wdata !== t.wdata)) begin
            report_mismatch($sformatf("test %0d memory write %07h %h, expected %07h %h",
                                      t.num, w.addr, w.wdata, t.addr, t.wdata));
        end
        if (!t.write && !t.exp_hit && rd_seen != 1)
            report_mismatch($sformatf("test %0d saw %0d line reads, expected 1", t.num, rd_seen));
        if ((t.write || t.exp_hit) && rd_seen != 0)
            report_mismatch($sformatf("test %0d saw %0d line reads, expected 0", t.num, rd_seen));
        if (errors == errs_before) begin
            passed++;
            $display("test %0d at %07h: ok", t.num, t.addr);
        end else begin
            $display("test %0d at %07h: failed", t.num, t.addr);
        end
    endtask

    // memory: write-through capture and line reads after 1 to 8 cycles
    initial begin : memory_model
        line_addr_t rd_addr;
        line_t      rd_line;
        int         lat;
        mem_rd_valid = 1'b0;
        mem_rd_line  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_wr_valid) mem_words[mem_wr.addr] = mem_wr.wdata;
            if (rst_n && mem_rd_req) begin
                rd_addr = mem_rd_addr;
                lat = 1;
                for (int i = 0; i < 3; i++) lat = lat + (int'(lfsr_next_bit()) << i);
                for (int o = 0; o < WORDS_PER_LINE; o++)
                    rd_line[o*WORD_BITS +: WORD_BITS] = mem_read({rd_addr, offset_t'(o)});
                repeat (lat) @(posedge clk);
                mem_rd_valid <= 1'b1;
                mem_rd_line  <= rd_line;
                @(posedge clk);
                mem_rd_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        load_stimulus();
        watchdog_cycles = tests.size() * 20 + 10;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (busy || resp_valid || mem_rd_req || mem_wr_valid)
            report_failure("outputs not idle after reset");
        if (tests.size() == 0) report_failure("no stimulus loaded");
        foreach (tests[i]) run_test(tests[i]);
        $display("%0d tests, %0d passed, %0d errors", tests.size(), passed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
